//--- Makefile
.PHONY: all compile run check clean

all: check

compile:
	verilator --binary --timing --top-module tb_uart_hub -f tb.f --Mdir obj_dir -o sim_uart_hub

run: compile
	./obj_dir/sim_uart_hub | tee sim.log

check: run
	grep -q "^TEST OK$$" sim.log

clean:
	rm -rf obj_dir sim.log

//--- common/uart_hub_pkg.sv
// n_chan must stay a power of two so chan_t wraps cleanly in the round-robin search
package uart_hub_pkg;

    localparam int n_chan = 4;                    // serial channels in the hub

    typedef logic [7:0]                byte_t;    // one serial data byte
    typedef logic [$clog2(n_chan)-1:0] chan_t;    // channel index / tag
    typedef logic [3:0]                credit_t;  // host receive credits held by the hub

    // host to hub, one byte for one channel
    typedef struct packed {
        logic  valid;                             // beat present this cycle
        chan_t chan;                              // destination channel
        byte_t data;                              // byte to send
    } tx_cmd_t;

    // hub to host, one received byte
    typedef struct packed {
        logic  valid;                             // single-cycle strobe
        chan_t chan;                              // channel it came in on
        byte_t data;                              // received byte
    } rx_beat_t;

endpackage

//--- logic/byte_fifo.sv
// pop_data is the head, valid whenever empty is low; push on full and pop on empty are ignored
module byte_fifo import uart_hub_pkg::*; #(
    parameter int fifo_depth = 4
) (
    input  logic  clk,
    input  logic  resetq,
    input  logic  push,
    input  byte_t push_data,
    input  logic  pop,
    output byte_t pop_data,
    output logic  full,
    output logic  empty
);
    localparam int ptr_w = (fifo_depth > 1) ? $clog2(fifo_depth) : 1;
    localparam int cnt_w = $clog2(fifo_depth + 1);

    byte_t            mem [fifo_depth];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] count;       // occupancy
    logic             do_push;
    logic             do_pop;

    function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] p);
        return (p == ptr_w'(fifo_depth - 1)) ? '0 : p + 1'b1;  // any depth wraps
    endfunction

    assign full     = (count == cnt_w'(fifo_depth));
    assign empty    = (count == '0);
    assign do_push  = push && !full;
    assign do_pop   = pop && !empty;
    assign pop_data = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push)
            mem[wr_ptr] <= push_data;
    end

    always_ff @(posedge clk) begin
        if (!resetq) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push)
                wr_ptr <= next_ptr(wr_ptr);
            if (do_pop)
                rd_ptr <= next_ptr(rd_ptr);
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;       // both or neither
            endcase
        end
    end

endmodule

//--- logic/rx_arbiter.sv
// at most one beat every other cycle; host must keep outstanding rx credits below 16
module rx_arbiter import uart_hub_pkg::*; (
    input  logic               clk,
    input  logic               resetq,
    input  logic  [n_chan-1:0] rx_ready,
    input  byte_t [n_chan-1:0] rx_data,
    output logic  [n_chan-1:0] rx_pop,
    input  logic               rx_credit,   // grants one beat
    output rx_beat_t           rx_beat
);
    credit_t credits;          // beats the host will accept
    chan_t   last;             // last channel served
    chan_t   pick;
    logic    pick_ok;
    logic    grant;
    logic    beat_valid;
    chan_t   beat_chan;
    byte_t   beat_data;

    // first ready channel after last, wrapping back to last itself
    always_comb begin
        chan_t idx;
        pick    = last;
        pick_ok = 1'b0;
        for (int i = 1; i <= n_chan; i++) begin
            idx = last + chan_t'(i);
            if (!pick_ok && rx_ready[idx]) begin
                pick    = idx;
                pick_ok = 1'b1;
            end
        end
    end

    // skip while a pop is in flight, the queue head is still stale
    assign grant   = pick_ok && (credits != '0) && !beat_valid;
    assign rx_beat = '{valid: beat_valid, chan: beat_chan, data: beat_data};

    always_ff @(posedge clk) begin
        if (!resetq) begin
            credits    <= '0;
            last       <= chan_t'(n_chan - 1);     // channel 0 goes first
            beat_valid <= 1'b0;
            rx_pop     <= '0;
        end else begin
            beat_valid <= grant;
            rx_pop     <= grant ? ({{(n_chan-1){1'b0}}, 1'b1} << pick) : '0;
            if (grant)
                last <= pick;
            credits <= credits + credit_t'(rx_credit) - credit_t'(beat_valid);  // spent as sent
        end
    end

    always_ff @(posedge clk) begin
        if (grant) begin
            beat_chan <= pick;
            beat_data <= rx_data[pick];
        end
    end

endmodule

//--- logic/uart_hub.sv
// host may send to a channel only while holding one of its fifo_depth tx credits
module uart_hub import uart_hub_pkg::*; #(
    parameter int freq_mhz   = 60,
    parameter int bauds      = 115200,
    parameter int fifo_depth = 4
) (
    input  logic              clk,
    input  logic              resetq,
    input  tx_cmd_t           tx_cmd,
    output logic [n_chan-1:0] tx_credit,
    input  logic              rx_credit,
    output rx_beat_t          rx_beat,
    output logic [n_chan-1:0] tx,
    input  logic [n_chan-1:0] rx
);
    logic  [n_chan-1:0] tx_push;    // decoded host beat
    logic  [n_chan-1:0] rx_ready;
    logic  [n_chan-1:0] rx_pop;
    byte_t [n_chan-1:0] rx_data;    // head of each rx queue

    for (genvar c = 0; c < n_chan; c++) begin : g_chan
        assign tx_push[c] = tx_cmd.valid && (tx_cmd.chan == chan_t'(c));

        uart_channel #(
            .freq_mhz  (freq_mhz),
            .bauds     (bauds),
            .fifo_depth(fifo_depth)
        ) chan0 (
            .clk      (clk),
            .resetq   (resetq),
            .tx_push  (tx_push[c]),
            .tx_data  (tx_cmd.data),    // shared, only the strobe is per channel
            .tx_credit(tx_credit[c]),
            .rx_pop   (rx_pop[c]),
            .rx_ready (rx_ready[c]),
            .rx_data  (rx_data[c]),
            .tx       (tx[c]),
            .rx       (rx[c])
        );
    end

    rx_arbiter arb0 (
        .clk      (clk),
        .resetq   (resetq),
        .rx_ready (rx_ready),
        .rx_data  (rx_data),
        .rx_pop   (rx_pop),
        .rx_credit(rx_credit),
        .rx_beat  (rx_beat)
    );

endmodule

//--- tb.f
common/uart_hub_pkg.sv
logic/byte_fifo.sv
uart/buart.sv
uart/uart_channel.sv
logic/rx_arbiter.sv
logic/uart_hub.sv
verification/tb_uart_hub.sv

//--- uart/buart.sv
// 8N1 only, no parity, break or error flags; baud divider fixed by freq_mhz and bauds
module buart import uart_hub_pkg::*; #(
    parameter int freq_mhz = 60,
    parameter int bauds    = 115200
) (
    input  logic  clk,
    input  logic  resetq,
    output logic  tx,
    input  logic  rx,
    input  logic  wr,        // load tx_data when not busy
    input  logic  rd,        // drop the held rx byte
    input  byte_t tx_data,
    output byte_t rx_data,
    output logic  busy,
    output logic  valid
);
    localparam int divider = freq_mhz * 1000000 / bauds;  // bit time is divider+2 clocks
    localparam int div_w   = $clog2(divider + 2) + 1;     // room to count past divider

    typedef enum logic [1:0] {
        rx_idle,             // waiting for a falling edge
        rx_start,            // walking to the middle of the start bit
        rx_bits,             // sampling the 8 data bits
        rx_stop              // one more bit time, then hand over
    } rx_state_t;

    rx_state_t        recv_state;
    logic [div_w-1:0] recv_divcnt;
    logic [2:0]       recv_bitcnt;     // data bit index
    byte_t            recv_pattern;    // shift register, lsb first
    byte_t            recv_buf_data;   // one byte of buffer
    logic             recv_buf_valid;
    logic             recv_tick;
    logic             recv_sample;
    logic             recv_done;

    logic [9:0]       send_pattern;    // stop, data, start
    logic [3:0]       send_bitcnt;     // bits left to shift out
    logic [div_w-1:0] send_divcnt;
    logic             send_dummy;      // idle frame pending after reset

    assign rx_data = recv_buf_data;
    assign valid   = recv_buf_valid;
    assign busy    = (send_bitcnt != '0) || send_dummy;
    assign tx      = send_pattern[0];

    assign recv_tick   = recv_divcnt > divider;
    assign recv_sample = (recv_state == rx_bits) && recv_tick;
    assign recv_done   = (recv_state == rx_stop) && recv_tick;

    always_ff @(posedge clk) begin
        if (!resetq) begin
            recv_state     <= rx_idle;
            recv_divcnt    <= '0;
            recv_bitcnt    <= '0;
            recv_buf_valid <= 1'b0;
        end else begin
            recv_divcnt <= recv_divcnt + 1'b1;
            if (rd)
                recv_buf_valid <= 1'b0;         // a new byte below still wins
            case (recv_state)
                rx_idle: begin
                    if (!rx)
                        recv_state <= rx_start;
                    recv_divcnt <= '0;
                end
                rx_start: begin
                    if (2 * recv_divcnt > divider) begin  // half a bit in
                        recv_state  <= rx_bits;
                        recv_divcnt <= '0;
                        recv_bitcnt <= '0;
                    end
                end
                rx_bits: begin
                    if (recv_sample) begin
                        recv_divcnt <= '0;
                        recv_bitcnt <= recv_bitcnt + 1'b1;
                        if (recv_bitcnt == 3'd7)
                            recv_state <= rx_stop;
                    end
                end
                default: begin
                    if (recv_done) begin
                        recv_buf_valid <= 1'b1;  // stop bit not checked
                        recv_state     <= rx_idle;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (recv_sample)
            recv_pattern <= {rx, recv_pattern[7:1]};
        if (recv_done)
            recv_buf_data <= recv_pattern;       // overwrites an unread byte
    end

    always_ff @(posedge clk) begin
        if (!resetq) begin
            send_pattern <= '1;                  // line idles high
            send_bitcnt  <= '0;
            send_divcnt  <= '0;
            send_dummy   <= 1'b1;
        end else begin
            send_divcnt <= send_divcnt + 1'b1;
            if (send_dummy && send_bitcnt == '0) begin
                send_pattern <= '1;              // 15 idle bits before first frame
                send_bitcnt  <= 4'd15;
                send_divcnt  <= '0;
                send_dummy   <= 1'b0;
            end else if (wr && send_bitcnt == '0) begin
                send_pattern <= {1'b1, tx_data, 1'b0};
                send_bitcnt  <= 4'd10;
                send_divcnt  <= '0;
            end else if (send_divcnt > divider && send_bitcnt != '0) begin
                send_pattern <= {1'b1, send_pattern[9:1]};
                send_bitcnt  <= send_bitcnt - 1'b1;
                send_divcnt  <= '0;
            end
        end
    end

endmodule

//--- uart/uart_channel.sv
// tx queue overflow is prevented only by host credits; a byte arriving on a full rx queue is lost
module uart_channel import uart_hub_pkg::*; #(
    parameter int freq_mhz   = 60,
    parameter int bauds      = 115200,
    parameter int fifo_depth = 4
) (
    input  logic  clk,
    input  logic  resetq,
    input  logic  tx_push,     // host byte for this channel
    input  byte_t tx_data,
    output logic  tx_credit,   // one pulse per byte handed to the uart
    input  logic  rx_pop,      // from the arbiter
    output logic  rx_ready,
    output byte_t rx_data,
    output logic  tx,
    input  logic  rx
);
    byte_t txq_data;           // head of the tx queue
    logic  txq_empty;
    logic  tx_go;              // uart takes a byte this cycle
    logic  uart_busy;
    logic  uart_valid;
    byte_t uart_rx_data;
    logic  rxq_empty;
    logic  rx_meta;            // two-flop sync on the serial input
    logic  rx_sync;

    assign tx_go    = !uart_busy && !txq_empty;
    assign rx_ready = !rxq_empty;

    always_ff @(posedge clk) begin
        if (!resetq) begin
            tx_credit <= 1'b0;
            rx_meta   <= 1'b1;             // idle line level
            rx_sync   <= 1'b1;
        end else begin
            tx_credit <= tx_go;            // credit back one cycle after hand-off
            rx_meta   <= rx;
            rx_sync   <= rx_meta;
        end
    end

    byte_fifo #(
        .fifo_depth(fifo_depth)
    ) txq0 (
        .clk      (clk),
        .resetq   (resetq),
        .push     (tx_push),
        .push_data(tx_data),
        .pop      (tx_go),
        .pop_data (txq_data),
        .full     (),                      // host credits keep it from filling past depth
        .empty    (txq_empty)
    );

    buart #(
        .freq_mhz(freq_mhz),
        .bauds   (bauds)
    ) uart0 (
        .clk    (clk),
        .resetq (resetq),
        .tx     (tx),
        .rx     (rx_sync),
        .wr     (tx_go),
        .rd     (uart_valid),              // drain the single-byte buffer at once
        .tx_data(txq_data),
        .rx_data(uart_rx_data),
        .busy   (uart_busy),
        .valid  (uart_valid)
    );

    byte_fifo #(
        .fifo_depth(fifo_depth)
    ) rxq0 (
        .clk      (clk),
        .resetq   (resetq),
        .push     (uart_valid),            // valid lasts one cycle thanks to rd
        .push_data(uart_rx_data),
        .pop      (rx_pop),
        .pop_data (rx_data),
        .full     (),                      // fifo drops the push itself
        .empty    (rxq_empty)
    );

endmodule

//--- verification/tb_uart_hub.sv
// tx looped back to rx per channel; at most 8 rx credits lent; rx queue overflow is not modeled
module tb_uart_hub import uart_hub_pkg::*; ();

    localparam int freq_mhz   = 1;
    localparam int bauds      = 250000;
    localparam int fifo_depth = 4;
    localparam int clk_period = 4;
    localparam int bit_clks   = freq_mhz * 1000000 / bauds + 2;  // divider+2 clocks per bit
    localparam int frame_clks = 10 * bit_clks;                     // 8N1 frame
    localparam int n_random   = 200;
    localparam int n_bp       = 3 * n_chan;                        // back-pressure burst
    localparam int n_total    = n_chan + n_random + n_bp;
    localparam int rx_limit   = 8;                                 // rx credits the host lends
    localparam int hold_clks  = 7 * frame_clks / 2;                // under fifo_depth frames

    logic              clk;
    logic              resetq;
    tx_cmd_t           tx_cmd;
    logic [n_chan-1:0] tx_credit;
    logic              rx_credit;
    rx_beat_t          rx_beat;
    logic [n_chan-1:0] tx;
    logic [n_chan-1:0] rx;

    integer seed;
    string  test_name;
    byte_t  exp_q [n_chan][$];   // scoreboard of bytes in flight per channel
    int     tx_sent [n_chan];    // host beats per channel
    int     tx_back [n_chan];    // tx_credit pulses seen
    int     tx_stalls;           // random sends held back by a full tx queue
    int     rx_out;              // granted minus received beats
    int     rx_seen;
    logic   hold_rx;             // host withholds rx credits
    int     mismatches;
    int     faults;

    assign rx = tx;              // loopback per channel

    uart_hub #(
        .freq_mhz  (freq_mhz),
        .bauds     (bauds),
        .fifo_depth(fifo_depth)
    ) dut0 (
        .clk      (clk),
        .resetq   (resetq),
        .tx_cmd   (tx_cmd),
        .tx_credit(tx_credit),
        .rx_credit(rx_credit),
        .rx_beat  (rx_beat),
        .tx       (tx),
        .rx       (rx)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    task automatic check_value(input string name, input int expected, input int actual);
        if (expected != actual) begin
            $display("MISMATCH %s expected %0h actual %0h at %0t", name, expected, actual, $time);
            mismatches++;
        end
    endtask

    task automatic report_fault(input string what);
        $display("ERROR %s at %0t", what, $time);
        faults++;
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;                                  // inputs move just after the edge
    endtask

    function automatic bit can_send(input chan_t c);
        return (tx_sent[c] - tx_back[c]) < fifo_depth;
    endfunction

    function automatic int pending_bytes();
        int n;
        n = 0;
        for (int c = 0; c < n_chan; c++)
            n += exp_q[c].size();
        return n;
    endfunction

    function automatic bit all_drained();
        bit ok;
        ok = (pending_bytes() == 0);
        for (int c = 0; c < n_chan; c++)
            if (tx_back[c] != tx_sent[c])
                ok = 1'b0;
        return ok;
    endfunction

    task automatic send_byte(input chan_t c, input byte_t d);
        tx_cmd = '{valid: 1'b1, chan: c, data: d};
        exp_q[c].push_back(d);
        tx_sent[c]++;                        // one credit spent
        next_cycle();
        tx_cmd = '{valid: 1'b0, chan: '0, data: '0};
    endtask

    task automatic send_when_credit(input chan_t c, input byte_t d);
        while (!can_send(c))
            next_cycle();
        send_byte(c, d);
    endtask

    task automatic wait_drained(input int max_clks);
        int n;
        n = 0;
        while (!all_drained() && n < max_clks) begin
            next_cycle();
            n++;
        end
        if (!all_drained())
            report_fault($sformatf("%s traffic did not drain within %0d clocks",
                                   test_name, max_clks));
    endtask

    // host grants one rx credit per cycle up to rx_limit
    initial begin
        rx_credit = 1'b0;
        forever begin
            next_cycle();
            rx_credit = resetq && !hold_rx && (rx_out < rx_limit);
        end
    end

    // monitor samples at negedge where inputs and outputs have settled
    always @(negedge clk) begin
        if (resetq) begin
            for (int c = 0; c < n_chan; c++) begin
                if (tx_credit[c]) begin
                    if (tx_back[c] >= tx_sent[c])
                        report_fault($sformatf("tx_credit on channel %0d with no byte queued", c));
                    tx_back[c]++;
                end
            end
            if (rx_beat.valid) begin
                if (rx_out == 0)
                    report_fault("rx_beat.valid rose while the host held no receive credit");
                if (exp_q[rx_beat.chan].size() == 0)
                    report_fault($sformatf("unexpected byte on channel %0d", rx_beat.chan));
                else
                    check_value({test_name, " data"}, int'(exp_q[rx_beat.chan].pop_front()),
                                int'(rx_beat.data));
                rx_seen++;
            end
            rx_out = rx_out + (rx_credit ? 1 : 0) - (rx_beat.valid ? 1 : 0);  // mirrors hub count
        end
    end

    initial begin
        int    sent;
        chan_t ch;
        seed      = 29412;
        resetq    = 1'b0;
        hold_rx   = 1'b0;
        tx_cmd    = '{valid: 1'b0, chan: '0, data: '0};
        test_name = "reset";
        repeat (5) @(posedge clk);
        #1;
        resetq = 1'b1;
        repeat (20) begin                    // lines idle and nothing returned yet
            @(negedge clk);
            check_value("reset tx lines", (1 << n_chan) - 1, int'(tx));
            check_value("reset rx_beat.valid", 0, int'(rx_beat.valid));
            check_value("reset tx_credit", 0, int'(tx_credit));
        end
        next_cycle();

        test_name = "loopback";
        for (int c = 0; c < n_chan; c++)
            send_byte(chan_t'(c), byte_t'($random(seed)));
        wait_drained(20 * frame_clks);       // includes the post-reset idle frame

        test_name = "random";
        sent = 0;
        while (sent < n_random) begin
            ch = chan_t'($random(seed));
            if (can_send(ch)) begin
                send_byte(ch, byte_t'($random(seed)));
                sent++;
            end else begin
                tx_stalls++;
                next_cycle();
            end
        end
        wait_drained(n_random * frame_clks);
        if (tx_stalls == 0)
            report_fault("no tx queue ever filled up to the host's credit limit");

        test_name = "rx backpressure";
        hold_rx   = 1'b1;
        for (int k = 0; k < n_bp; k++)
            send_when_credit(chan_t'(k % n_chan), byte_t'($random(seed)));
        repeat (hold_clks - n_bp) next_cycle();
        if (pending_bytes() == 0)
            report_fault("no bytes were held back while rx credits were withheld");
        hold_rx = 1'b0;                      // credits resume
        wait_drained(n_bp * frame_clks);

        for (int c = 0; c < n_chan; c++)
            check_value($sformatf("tx credits ch%0d", c), tx_sent[c], tx_back[c]);
        check_value("bytes received", n_total, rx_seen);
        $display("errors: %0d mismatches, %0d other failures", mismatches, faults);
        if (mismatches == 0 && faults == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

    // 12 frame times per byte plus slack for reset and idle
    initial begin
        #(n_total * 12 * frame_clks * clk_period + 1000 * clk_period);
        $display("watchdog expired, the simulation ran past its time limit");
        $display("TEST FAILED");
        $finish;
    end

endmodule
